// ==== hw/lcd_consts.svh ====
`ifndef LCD_CONSTS_SVH
`define LCD_CONSTS_SVH

// panel opcodes, ILI9341 command set subset
`define LCD_OP_NOP      8'h00
`define LCD_OP_SWRESET  8'h01
`define LCD_OP_SLPIN    8'h10
`define LCD_OP_SLPOUT   8'h11
`define LCD_OP_DISPOFF  8'h28
`define LCD_OP_DISPON   8'h29
`define LCD_OP_CASET    8'h2A
`define LCD_OP_PASET    8'h2B
`define LCD_OP_RAMWR    8'h2C
`define LCD_OP_PIXFMT   8'h3A

// largest number of parameter bytes per command
`define LCD_MAX_PARAMS  4

// strobe widths after reset, in clock cycles
`define LCD_WR_LOW_RST  4'd2
`define LCD_WR_HIGH_RST 4'd2

// wait after reset/sleep commands
`define LCD_DELAY_RST   24'd1000

`endif

// ==== hw/lcd_pkg.sv ====
package lcd_pkg;

    // host register selects
    typedef enum logic [1:0] {
        REG_TIMING = 2'd0,
        REG_DELAY  = 2'd1,
        REG_PARAMS = 2'd2,
        REG_CMD    = 2'd3
    } reg_sel_e;

    // one host write, held stable while req is high
    typedef struct packed {
        reg_sel_e    sel;
        logic [31:0] data;
    } host_req_t;

    // live bus timing, widths in clock cycles
    typedef struct packed {
        logic [3:0]  wr_low;   // wrx low phase
        logic [3:0]  wr_high;  // wrx high phase
        logic [23:0] delay;    // post-command wait
    } bus_timing_t;

    // one queued panel transaction
    typedef struct packed {
        logic [7:0]  opcode;
        logic [2:0]  nparam;   // only for unknown opcodes
        logic [31:0] params;   // first byte in 31..24
    } lcd_txn_t;

endpackage

// ==== hw/lcd_cmd_regs.sv ====
`timescale 1ns/1ps
`include "lcd_consts.svh"

module lcd_cmd_regs (
    input  logic                clk,
    input  logic                nrst,
    input  lcd_pkg::host_req_t  host,
    input  logic                req,
    output logic                ack,
    output lcd_pkg::bus_timing_t timing,
    output lcd_pkg::lcd_txn_t   txn,
    output logic                txn_req,
    input  logic                txn_ack,
    output logic                pending
);

    import lcd_pkg::*;

    logic        slot_full;       // one-deep transaction slot
    logic [31:0] params_q;        // last REG_PARAMS value
    logic        wr_apply;
    logic        is_cmd;
    logic [3:0]  wr_low_new;
    logic [3:0]  wr_high_new;
    logic [2:0]  nparam_new;

    assign is_cmd = (host.sel == REG_CMD);

    // a command write waits for the slot to drain
    assign wr_apply = req && !ack && (!is_cmd || !slot_full);

    // zero widths would stall the strobe counter, force them to 1
    always_comb begin
        wr_low_new  = (host.data[3:0] == 4'd0) ? 4'd1 : host.data[3:0];
        wr_high_new = (host.data[7:4] == 4'd0) ? 4'd1 : host.data[7:4];
        if (host.data[10:8] > `LCD_MAX_PARAMS)
            nparam_new = 3'(`LCD_MAX_PARAMS);
        else
            nparam_new = host.data[10:8];
    end

    // host handshake and configuration
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            ack            <= 1'b0;
            timing.wr_low  <= `LCD_WR_LOW_RST;
            timing.wr_high <= `LCD_WR_HIGH_RST;
            timing.delay   <= `LCD_DELAY_RST;
        end else begin
            if (ack) begin
                if (!req)
                    ack <= 1'b0;  // host has released the request
            end else if (wr_apply) begin
                ack <= 1'b1;
            end

            if (wr_apply) begin
                case (host.sel)
                    REG_TIMING: begin
                        timing.wr_low  <= wr_low_new;
                        timing.wr_high <= wr_high_new;
                    end
                    REG_DELAY: timing.delay <= host.data[23:0];
                    default: ;  // params and cmd handled below
                endcase
            end
        end
    end

    // slot state, cleared once the writer reports completion
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            slot_full <= 1'b0;
        end else begin
            if (slot_full && txn_ack)
                slot_full <= 1'b0;
            else if (wr_apply && is_cmd)
                slot_full <= 1'b1;
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (wr_apply && host.sel == REG_PARAMS)
            params_q <= host.data;

        if (wr_apply && is_cmd) begin
            txn.opcode <= host.data[7:0];
            txn.nparam <= nparam_new;
            txn.params <= params_q;  // parameters as written so far
        end
    end

    assign txn_req = slot_full;
    assign pending = slot_full;

endmodule

// ==== hw/lcd_bus_writer.sv ====
`timescale 1ns/1ps
`include "lcd_consts.svh"

module lcd_bus_writer (
    input  logic                 clk,
    input  logic                 nrst,
    input  lcd_pkg::bus_timing_t timing,
    input  lcd_pkg::lcd_txn_t    txn,
    input  logic                 txn_req,
    output logic                 txn_ack,
    output logic                 active,
    output logic [7:0]           d,
    output logic                 csx,
    output logic                 dcx,
    output logic                 wrx,
    output logic                 rdx
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_CMD,
        S_LOW,
        S_HIGH,
        S_SHIFT,
        S_DELAY,
        S_ACK
    } state_e;

    state_e      state;
    logic [7:0]  op_q;        // opcode of the running transaction
    logic [31:0] sr;          // parameter shift register, msb first
    logic [2:0]  nleft;       // parameter bytes still to send
    logic [3:0]  cnt;         // strobe phase counter
    logic [23:0] dly;         // post-command delay counter
    logic [2:0]  nparam_lut;
    logic        delay_op;

    // parameter count per opcode, unknown ones use the host count
    always_comb begin
        case (txn.opcode)
            `LCD_OP_CASET,
            `LCD_OP_PASET,
            `LCD_OP_RAMWR:   nparam_lut = 3'(`LCD_MAX_PARAMS);
            `LCD_OP_PIXFMT:  nparam_lut = 3'd1;
            `LCD_OP_SWRESET,
            `LCD_OP_SLPIN,
            `LCD_OP_SLPOUT,
            `LCD_OP_DISPON,
            `LCD_OP_DISPOFF,
            `LCD_OP_NOP:     nparam_lut = 3'd0;
            default:         nparam_lut = txn.nparam;
        endcase
    end

    // panel needs settling time after these
    always_comb begin
        case (op_q)
            `LCD_OP_SWRESET,
            `LCD_OP_SLPIN,
            `LCD_OP_SLPOUT: delay_op = 1'b1;
            default:        delay_op = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state   <= S_IDLE;
            csx     <= 1'b1;
            wrx     <= 1'b1;
            dcx     <= 1'b0;
            d       <= 8'h00;
            txn_ack <= 1'b0;
            nleft   <= 3'd0;
            cnt     <= 4'd0;
            dly     <= 24'd0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (txn_req) begin
                        nleft <= nparam_lut;
                        state <= S_CMD;
                    end
                end

                // select the panel and present the command byte
                S_CMD: begin
                    csx   <= 1'b0;
                    dcx   <= 1'b0;
                    d     <= op_q;
                    wrx   <= 1'b0;
                    cnt   <= 4'd1;
                    state <= S_LOW;
                end

                // shift is the first low cycle of a parameter byte
                S_LOW, S_SHIFT: begin
                    if (state == S_SHIFT)
                        nleft <= nleft - 3'd1;
                    if (cnt >= timing.wr_low) begin
                        wrx   <= 1'b1;  // panel latches d here
                        cnt   <= 4'd1;
                        state <= S_HIGH;
                    end else begin
                        cnt   <= cnt + 4'd1;
                        state <= S_LOW;
                    end
                end

                S_HIGH: begin
                    if (cnt >= timing.wr_high) begin
                        cnt <= 4'd1;
                        if (nleft != 3'd0) begin
                            d     <= sr[31:24];
                            dcx   <= 1'b1;
                            wrx   <= 1'b0;
                            state <= S_SHIFT;
                        end else begin
                            csx <= 1'b1;  // end of transaction on the bus
                            dcx <= 1'b0;
                            if (delay_op && timing.delay != 24'd0) begin
                                dly   <= 24'd1;
                                state <= S_DELAY;
                            end else begin
                                txn_ack <= 1'b1;
                                state   <= S_ACK;
                            end
                        end
                    end else begin
                        cnt <= cnt + 4'd1;
                    end
                end

                S_DELAY: begin
                    if (dly >= timing.delay) begin
                        txn_ack <= 1'b1;
                        state   <= S_ACK;
                    end else begin
                        dly <= dly + 24'd1;
                    end
                end

                // hold ack until the slot has been released
                S_ACK: begin
                    if (!txn_req) begin
                        txn_ack <= 1'b0;
                        state   <= S_IDLE;
                    end
                end

                default: state <= S_IDLE;
            endcase
        end
    end

    // payload capture and parameter shifting
    always_ff @(posedge clk) begin
        if (state == S_IDLE && txn_req) begin
            op_q <= txn.opcode;
            sr   <= txn.params;
        end else if (state == S_SHIFT) begin
            sr <= {sr[23:0], 8'h00};  // next byte to the top
        end
    end

    assign active = (state != S_IDLE);
    assign rdx    = 1'b1;  // write-only port

endmodule

// ==== hw/lcd_ctrl.sv ====
`timescale 1ns/1ps

module lcd_ctrl (
    input  logic               clk,
    input  logic               nrst,
    input  lcd_pkg::host_req_t host,
    input  logic               req,
    output logic               ack,
    output logic               busy,
    output logic [7:0]         d,
    output logic               csx,
    output logic               dcx,
    output logic               wrx,
    output logic               rdx
);

    lcd_pkg::bus_timing_t timing;   // live strobe and delay config
    lcd_pkg::lcd_txn_t    txn;
    logic                 txn_req;
    logic                 txn_ack;
    logic                 pending;  // slot holds a transaction
    logic                 active;   // writer is on the bus

    lcd_cmd_regs u_regs (
        .clk     (clk),
        .nrst    (nrst),
        .host    (host),
        .req     (req),
        .ack     (ack),
        .timing  (timing),
        .txn     (txn),
        .txn_req (txn_req),
        .txn_ack (txn_ack),
        .pending (pending)
    );

    lcd_bus_writer u_writer (
        .clk     (clk),
        .nrst    (nrst),
        .timing  (timing),
        .txn     (txn),
        .txn_req (txn_req),
        .txn_ack (txn_ack),
        .active  (active),
        .d       (d),
        .csx     (csx),
        .dcx     (dcx),
        .wrx     (wrx),
        .rdx     (rdx)
    );

    assign busy = pending | active;

endmodule

// ==== test/tb_lcd_ctrl.sv ====
`timescale 1ns/1ps
`include "lcd_consts.svh"

module tb_lcd_ctrl;

    import lcd_pkg::*;

    localparam int WAIT_LIMIT = 5000;  // cycles per wait loop
    localparam int DELAY_CYC  = 40;

    logic       clk;
    logic       nrst;
    host_req_t  host;
    logic       req;
    logic       ack;
    logic       busy;
    logic [7:0] d;
    logic       csx;
    logic       dcx;
    logic       wrx;
    logic       rdx;

    // bus capture filled by the monitor
    logic [8:0] bytes_q[$];  // {dcx, d} per latched byte
    int         csx_fall_q[$];
    int         csx_rise_q[$];
    int         low_w_q[$];
    int         high_w_q[$];  // high phases between bytes only
    int         cyc;
    int         low_run;
    int         high_run;
    logic       prev_csx;
    logic       prev_wrx;
    logic       rdx_fault;
    int         errors;
    integer     seed;

    lcd_ctrl uut (
        .clk  (clk),
        .nrst (nrst),
        .host (host),
        .req  (req),
        .ack  (ack),
        .busy (busy),
        .d    (d),
        .csx  (csx),
        .dcx  (dcx),
        .wrx  (wrx),
        .rdx  (rdx)
    );

    always #50 clk = ~clk;

    // panel side monitor sampling mid-cycle where outputs are settled
    always @(negedge clk) begin
        if (nrst) begin
            cyc = cyc + 1;
            if (prev_csx && !csx)
                csx_fall_q.push_back(cyc);
            if (!prev_csx && csx)
                csx_rise_q.push_back(cyc);
            if (!wrx) begin
                if (prev_wrx && !csx && high_run > 0)
                    high_w_q.push_back(high_run);
                low_run  = low_run + 1;
                high_run = 0;
            end else begin
                if (!prev_wrx) begin
                    low_w_q.push_back(low_run);
                    if (!csx)
                        bytes_q.push_back({dcx, d});  // latched on this rise
                end
                low_run  = 0;
                high_run = csx ? 0 : high_run + 1;
            end
            if (rdx !== 1'b1 && !rdx_fault) begin
                rdx_fault = 1'b1;
                errors++;
                $display("rdx left its idle high level at %0t", $time);
            end
            prev_csx = csx;
            prev_wrx = wrx;
        end
    end

    task automatic finish_run();
        $display("%0d errors", errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    endtask

    task automatic timeout_abort(input string what);
        errors++;
        $display("Timeout at %0t: %s", $time, what);
        finish_run();
    endtask

    task automatic check_byte(input string name, input logic [7:0] got,
                              input logic [7:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    // bytes per opcode as the panel command set defines them
    function automatic int param_count(input lcd_txn_t t);
        case (t.opcode)
            `LCD_OP_CASET, `LCD_OP_PASET, `LCD_OP_RAMWR: return `LCD_MAX_PARAMS;
            `LCD_OP_PIXFMT: return 1;
            `LCD_OP_SWRESET, `LCD_OP_SLPIN, `LCD_OP_SLPOUT,
            `LCD_OP_DISPON, `LCD_OP_DISPOFF, `LCD_OP_NOP: return 0;
            default: return int'(t.nparam);
        endcase
    endfunction

    function automatic lcd_txn_t expect_txn(input logic [7:0] op, input logic [2:0] np,
                                            input logic [31:0] p);
        lcd_txn_t t;
        t.opcode = op;
        t.nparam = (np > `LCD_MAX_PARAMS) ? 3'(`LCD_MAX_PARAMS) : np;
        t.params = p;
        return t;
    endfunction

    function automatic logic [31:0] cmd_word(input logic [7:0] op, input logic [2:0] np);
        return {21'd0, np, op};
    endfunction

    // pops one transaction off the capture queue
    task automatic check_txn(input string name, input lcd_txn_t exp);
        int         n;
        int         i;
        logic [8:0] b;
        logic [31:0] sr;
        n  = param_count(exp);
        sr = exp.params;
        if (bytes_q.size() < n + 1) begin
            errors++;
            $display("%s: only %0d bytes seen on the bus, %0d expected",
                     name, bytes_q.size(), n + 1);
            bytes_q.delete();
        end else begin
            b = bytes_q.pop_front();
            check_bit({name, " command dcx"}, b[8], 1'b0);
            check_byte({name, " command byte"}, b[7:0], exp.opcode);
            for (i = 0; i < n; i++) begin
                b = bytes_q.pop_front();
                check_bit({name, " param dcx"}, b[8], 1'b1);
                check_byte({name, " param byte"}, b[7:0], sr[31:24]);
                sr = sr << 8;  // msb first
            end
        end
    endtask

    task automatic clear_capture();
        bytes_q.delete();
        csx_fall_q.delete();
        csx_rise_q.delete();
        low_w_q.delete();
        high_w_q.delete();
    endtask

    // four-phase host write entered 1 ns after a rising edge
    task automatic host_write(input reg_sel_e sel, input logic [31:0] data);
        int n;
        host.sel  = sel;
        host.data = data;
        req       = 1'b1;
        n         = 0;
        while (ack !== 1'b1 && n < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (ack !== 1'b1)
            timeout_abort("host ack never rose");
        req = 1'b0;
        n   = 0;
        while (ack !== 1'b0 && n < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (ack !== 1'b0)
            timeout_abort("host ack never fell after req dropped");
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while ((busy !== 1'b0 || csx !== 1'b1) && n < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (busy !== 1'b0 || csx !== 1'b1)
            timeout_abort("controller stayed busy");
    endtask

    task automatic run_one(input string name, input logic [7:0] op, input logic [2:0] np,
                           input logic [31:0] p);
        clear_capture();
        host_write(REG_PARAMS, p);
        host_write(REG_CMD, cmd_word(op, np));
        check_bit({name, " busy while queued"}, busy, 1'b1);
        wait_idle();
        check_txn(name, expect_txn(op, np, p));
        check_count({name, " extra bytes"}, bytes_q.size(), 0);
        check_count({name, " csx falls"}, csx_fall_q.size(), 1);
        check_count({name, " csx rises"}, csx_rise_q.size(), 1);
    endtask

    task automatic test_reset();
        check_bit("csx", csx, 1'b1);
        check_bit("wrx", wrx, 1'b1);
        check_bit("rdx", rdx, 1'b1);
        check_bit("dcx", dcx, 1'b0);
        check_bit("busy", busy, 1'b0);
        check_bit("ack", ack, 1'b0);
        check_byte("d", d, 8'h00);
    endtask

    task automatic test_counts();
        run_one("caset", `LCD_OP_CASET, 3'd0, $random(seed));
        run_one("unknown np2", 8'hB5, 3'd2, $random(seed));
        run_one("unknown np7", 8'hC7, 3'd7, $random(seed));  // clamps to 4
        run_one("dispon np3", `LCD_OP_DISPON, 3'd3, $random(seed));
    endtask

    // CASET gives five low pulses and four gaps
    task automatic check_widths(input string name, input int wl, input int wh);
        int i;
        check_count({name, " low pulses"}, low_w_q.size(), `LCD_MAX_PARAMS + 1);
        check_count({name, " high gaps"}, high_w_q.size(), `LCD_MAX_PARAMS);
        for (i = 0; i < low_w_q.size(); i++)
            check_count({name, " wrx low width"}, low_w_q[i], wl);
        for (i = 0; i < high_w_q.size(); i++)
            check_count({name, " wrx high width"}, high_w_q[i], wh);
    endtask

    task automatic test_timing();
        host_write(REG_TIMING, 32'h0000_0053);
        run_one("caset 3/5", `LCD_OP_CASET, 3'd0, $random(seed));
        check_widths("timing 3/5", 3, 5);
        host_write(REG_TIMING, 32'h0000_0000);
        run_one("caset 0/0", `LCD_OP_CASET, 3'd0, $random(seed));
        check_widths("timing 0/0", 1, 1);
        host_write(REG_TIMING, 32'h0000_0022);
    endtask

    // command then NOP back to back with the gap measured between csx frames
    task automatic check_gap(input string name, input logic [7:0] op, input bit long_gap);
        int gap;
        clear_capture();
        host_write(REG_CMD, cmd_word(op, 3'd0));
        host_write(REG_CMD, cmd_word(`LCD_OP_NOP, 3'd0));
        wait_idle();
        check_txn(name, expect_txn(op, 3'd0, 32'd0));
        check_txn({name, " nop"}, expect_txn(`LCD_OP_NOP, 3'd0, 32'd0));
        if (csx_fall_q.size() != 2 || csx_rise_q.size() != 2) begin
            errors++;
            $display("%s: expected two csx frames, saw %0d falls and %0d rises",
                     name, csx_fall_q.size(), csx_rise_q.size());
        end else begin
            gap = csx_fall_q[1] - csx_rise_q[0];
            if (long_gap && (gap < DELAY_CYC || gap >= 2 * DELAY_CYC)) begin
                errors++;
                $display("%s: %0d idle cycles before the next command, %0d to %0d expected",
                         name, gap, DELAY_CYC, 2 * DELAY_CYC - 1);
            end else if (!long_gap && gap >= DELAY_CYC) begin
                errors++;
                $display("%s: %0d idle cycles, no post-command wait expected", name, gap);
            end
        end
    endtask

    task automatic test_delay();
        host_write(REG_DELAY, DELAY_CYC);
        check_gap("slpout", `LCD_OP_SLPOUT, 1'b1);
        check_gap("dispoff", `LCD_OP_DISPOFF, 1'b0);
    endtask

    task automatic test_backpressure();
        logic [31:0] p1;
        logic [31:0] p2;
        p1 = $random(seed);
        p2 = $random(seed);
        clear_capture();
        host_write(REG_PARAMS, p1);
        host_write(REG_CMD, cmd_word(`LCD_OP_CASET, 3'd0));
        host_write(REG_PARAMS, p2);
        check_count("csx rises before second command", csx_rise_q.size(), 0);
        host_write(REG_CMD, cmd_word(`LCD_OP_PASET, 3'd0));
        check_count("csx rises at second ack", csx_rise_q.size(), 1);
        wait_idle();
        check_txn("first caset", expect_txn(`LCD_OP_CASET, 3'd0, p1));
        check_txn("second paset", expect_txn(`LCD_OP_PASET, 3'd0, p2));
        check_count("back-pressure extra bytes", bytes_q.size(), 0);
        check_count("back-pressure csx frames", csx_rise_q.size(), 2);
    endtask

    initial begin
        clk       = 1'b0;
        nrst      = 1'b0;
        host      = '0;
        req       = 1'b0;
        errors    = 0;
        seed      = 11762;
        cyc       = 0;
        low_run   = 0;
        high_run  = 0;
        prev_csx  = 1'b1;
        prev_wrx  = 1'b1;
        rdx_fault = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        nrst = 1'b1;
        @(posedge clk);
        #1;
        test_reset();
        test_counts();
        test_timing();
        test_delay();
        test_backpressure();
        finish_run();
    end

endmodule

// ==== lcd_ctrl.f ====
+incdir+hw
hw/lcd_pkg.sv
hw/lcd_cmd_regs.sv
hw/lcd_bus_writer.sv
hw/lcd_ctrl.sv
test/tb_lcd_ctrl.sv

// ==== build.sh ====
#!/bin/sh
# compile and run the lcd_ctrl testbench with Verilator

cd "$(dirname "$0")" || exit 1

OBJ=obj_dir
LOG=sim.log

verilator --binary --timing -Wno-fatal -f lcd_ctrl.f \
    --top-module tb_lcd_ctrl -Mdir "$OBJ"
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

"./$OBJ/Vtb_lcd_ctrl" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "ERRORS FOUND" "$LOG"; then
    echo "simulation failed, see $LOG"
    exit 1
fi

echo "simulation passed"
exit 0
